// File: source/npu_cfg_pkg.sv
package npu_cfg_pkg;

  localparam int npu_data_w = 16;  // Samples, counts, coefficients, results
  localparam int npu_acc_w  = 40;  // MAC accumulator
  localparam int npu_idx_w  = 4;   // 16 coefficient slots

  // Kind field in bits 31..30, other codes are dropped by the decoder
  typedef enum logic [1:0] {
    cfg_kind_count = 2'b01,        // Input or output count
    cfg_kind_coef  = 2'b10         // Weight or gain load
  } npu_cfg_kind_e;

  // Same 32 bits, read either as a count write or a coefficient write
  typedef union packed {
    struct packed {
      npu_cfg_kind_e         kind;
      logic                  sel_out;  // 0 input count, 1 output count
      logic [12:0]           rsvd;
      logic [npu_data_w-1:0] value;
    } count;
    struct packed {
      npu_cfg_kind_e         kind;
      logic                  bank;     // 0 weight, 1 gain
      logic [8:0]            rsvd;
      logic [npu_idx_w-1:0]  index;    // Bits 19..16
      logic [npu_data_w-1:0] value;
    } coef;
  } npu_cfg_word_u;

endpackage

// File: source/npu_bus_pkg.sv
package npu_bus_pkg;

  // Word addresses seen on adr
  typedef enum logic [1:0] {
    addr_cfg_push = 2'd0,  // Write
    addr_in_push  = 2'd1,  // Write
    addr_out_pop  = 2'd2,  // Read
    addr_status   = 2'd3   // Read
  } npu_addr_e;

  localparam int stat_w         = 8;
  localparam int stat_idle      = 0;
  localparam int stat_config    = 1;
  localparam int stat_compute   = 2;
  localparam int stat_stall     = 3;
  localparam int stat_cfg_empty = 4;
  localparam int stat_in_empty  = 5;
  localparam int stat_out_empty = 6;
  localparam int stat_out_full  = 7;

endpackage

// File: source/npu_fifo.sv
`timescale 1ns/1ps

module npu_fifo #(
  parameter int depth = 8,
  parameter int width = npu_cfg_pkg::npu_data_w
) (
  input  logic             CLK,
  input  logic             RST,
  input  logic             push,
  input  logic [width-1:0] push_data,
  input  logic             pop,
  output logic [width-1:0] pop_data,
  output logic             empty,
  output logic             full
);

  localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int cnt_w = $clog2(depth + 1);

  logic [width-1:0] mem [depth];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [cnt_w-1:0] count;     // Occupancy
  logic             do_push;
  logic             do_pop;

  assign do_push  = push & ~full;        // Push on full is dropped
  assign do_pop   = pop & ~empty;        // Pop on empty is dropped
  assign empty    = (count == '0);
  assign full     = (count == cnt_w'(depth));
  assign pop_data = mem[rd_ptr];         // Show-ahead head

  always_ff @(posedge CLK) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge CLK) begin
    if (RST) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;  // Wrap any depth
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + cnt_w'(do_push) - cnt_w'(do_pop);
    end
  end

endmodule

// File: source/npu_wb_slave.sv
`timescale 1ns/1ps

module npu_wb_slave (
  input  logic                              CLK,
  input  logic                              RST,
  input  logic                              cyc,
  input  logic                              stb,
  input  logic                              we,
  input  logic [1:0]                        adr,
  input  logic [31:0]                       dat_i,
  output logic                              ack,
  output logic [31:0]                       dat_o,
  output logic                              cfg_push,
  output logic                              in_push,
  output logic [31:0]                       push_data,
  input  logic                              cfg_full,
  input  logic                              in_full,
  output logic                              out_pop,
  input  logic [npu_cfg_pkg::npu_data_w-1:0] out_data,
  input  logic                              out_empty,
  input  logic [npu_bus_pkg::stat_w-1:0]    status
);
  import npu_bus_pkg::*;

  npu_addr_e addr;
  logic      ready;   // Target can take the operation now
  logic      go;

  assign addr = npu_addr_e'(adr);

  // Back-pressure: full push target or empty pop source holds ack low
  always_comb begin
    case (addr)
      addr_cfg_push: ready = ~we | ~cfg_full;
      addr_in_push:  ready = ~we | ~in_full;
      addr_out_pop:  ready = we | ~out_empty;
      default:       ready = 1'b1;             // Status never waits
    endcase
  end

  assign go = cyc & stb & ~ack & ready;       // No re-issue on the ack cycle

  always_ff @(posedge CLK) begin
    if (RST) begin
      ack <= 1'b0;
    end else begin
      ack <= go;                              // One-cycle pulse
    end
  end

  // FIFO side effects land on the ack cycle, host still holds adr and we
  assign cfg_push  = ack & we & (addr == addr_cfg_push);
  assign in_push   = ack & we & (addr == addr_in_push);
  assign out_pop   = ack & ~we & (addr == addr_out_pop);
  assign push_data = dat_i;

  always_comb begin
    case (addr)
      addr_out_pop: dat_o = 32'(out_data);    // Zero-extended head
      addr_status:  dat_o = 32'(status);
      default:      dat_o = '0;
    endcase
  end

endmodule

// File: source/npu_config_decode.sv
`timescale 1ns/1ps

module npu_config_decode (
  input  logic                              CLK,
  input  logic                              RST,
  input  logic                              state_config,
  input  logic                              cfg_empty,
  input  logic [31:0]                       cfg_word,
  output logic                              cfg_pop,
  output logic [npu_cfg_pkg::npu_data_w-1:0] count_data,
  output logic                              input_reg_enable,
  output logic                              output_reg_enable,
  output logic                              coef_write,
  output logic                              coef_bank,
  output logic [npu_cfg_pkg::npu_idx_w-1:0]  coef_index,
  output logic [npu_cfg_pkg::npu_data_w-1:0] coef_value
);
  import npu_cfg_pkg::*;

  npu_cfg_word_u word;

  assign word    = cfg_word;
  assign cfg_pop = state_config & ~cfg_empty;  // One word per cycle

  // Strobes follow the pop by one register stage
  always_ff @(posedge CLK) begin
    if (RST) begin
      input_reg_enable  <= 1'b0;
      output_reg_enable <= 1'b0;
      coef_write        <= 1'b0;
    end else begin
      input_reg_enable  <= 1'b0;
      output_reg_enable <= 1'b0;
      coef_write        <= 1'b0;
      if (cfg_pop) begin
        case (word.count.kind)
          cfg_kind_count: begin
            input_reg_enable  <= ~word.count.sel_out;
            output_reg_enable <= word.count.sel_out;
          end
          cfg_kind_coef:  coef_write <= 1'b1;
          default:        ;                     // Unknown kind, word dropped
        endcase
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (cfg_pop) begin
      count_data <= word.count.value;
      coef_bank  <= word.coef.bank;
      coef_index <= word.coef.index;
      coef_value <= word.coef.value;
    end
  end

endmodule

// File: source/npu_state_machine.sv
`timescale 1ns/1ps

module npu_state_machine (
  input  logic                              CLK,
  input  logic                              RST,
  input  logic [npu_cfg_pkg::npu_data_w-1:0] state_data_in,       // Count value from decode
  input  logic                              output_reg_enable,
  input  logic                              input_reg_enable,
  input  logic                              config_fifo_empty,
  input  logic                              input_fifo_empty,
  input  logic                              sched_input_read,
  input  logic                              output_fifo_full,
  input  logic                              sched_output_write,
  output logic                              input_fifo_read_en,
  output logic                              output_fifo_write_en,
  output logic                              state_idle,
  output logic                              state_stall,
  output logic                              state_compute,
  output logic                              state_config,
  output logic                              inputs_done
);
  import npu_cfg_pkg::*;

  logic [npu_data_w-1:0] input_cnt;
  logic [npu_data_w-1:0] input_cnt_cur;
  logic [npu_data_w-1:0] output_cnt;
  logic [npu_data_w-1:0] output_cnt_cur;
  logic                  input_stall;
  logic                  output_stall;
  logic                  input_cnt_equals;
  logic                  outputs_done;
  logic                  output_blocked;     // Result waiting on a full FIFO

  assign input_cnt_equals = (input_cnt == input_cnt_cur);
  assign outputs_done     = inputs_done & (output_cnt == output_cnt_cur);
  assign output_blocked   = sched_output_write & inputs_done & ~outputs_done & output_fifo_full;

  // Count-reached cycle blocks the read so the next job keeps its first sample
  assign input_fifo_read_en = sched_input_read & ~inputs_done & ~input_cnt_equals
                              & state_compute;
  // Full FIFO blocks the write, result stays in npu_result
  assign output_fifo_write_en = sched_output_write & inputs_done & ~outputs_done
                                & ~output_fifo_full & state_compute;

  //////////////////////////////////////////////////////////////////////
  // One-hot job states
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge CLK) begin
    if (RST) begin
      state_idle     <= 1'b1;
      state_stall    <= 1'b0;
      state_compute  <= 1'b0;
      state_config   <= 1'b0;
      input_cnt      <= '0;
      input_cnt_cur  <= '0;
      output_cnt     <= '0;
      output_cnt_cur <= '0;
      input_stall    <= 1'b0;
      output_stall   <= 1'b0;
      inputs_done    <= 1'b0;
    end else if (state_idle) begin
      if (~input_fifo_empty) begin                  // Input wins over config
        state_idle    <= 1'b0;
        state_compute <= 1'b1;
      end else if (~config_fifo_empty) begin
        state_idle   <= 1'b0;
        state_config <= 1'b1;
      end
    end else if (state_stall) begin
      if (input_stall && ~input_fifo_empty) begin   // Data arrived
        state_stall   <= 1'b0;
        state_compute <= 1'b1;
        input_stall   <= 1'b0;
      end
      if (output_stall && ~output_fifo_full) begin  // Host popped
        state_stall   <= 1'b0;
        state_compute <= 1'b1;
        output_stall  <= 1'b0;
      end
    end else if (state_compute) begin
      if (inputs_done) begin
        input_cnt_cur <= '0;
        if (outputs_done) begin                     // Job finished
          state_idle     <= 1'b1;
          state_compute  <= 1'b0;
          output_cnt_cur <= '0;
          inputs_done    <= 1'b0;
        end
      end
      if (input_fifo_read_en) begin
        input_cnt_cur <= input_cnt_cur + 1'b1;
      end
      if (output_fifo_write_en) begin
        output_cnt_cur <= output_cnt_cur + 1'b1;
      end
      if (input_cnt_equals) begin
        inputs_done <= 1'b1;
      end
      if (~(inputs_done || input_cnt_equals) && input_fifo_empty) begin  // Starved
        state_stall   <= 1'b1;
        state_compute <= 1'b0;
        input_stall   <= 1'b1;
      end
      if (output_blocked) begin                     // Output FIFO full
        state_stall   <= 1'b1;
        state_compute <= 1'b0;
        output_stall  <= 1'b1;
      end
    end else if (state_config) begin
      if (config_fifo_empty) begin
        state_config <= 1'b0;
        state_idle   <= 1'b1;
      end
      if (output_reg_enable) begin
        output_cnt <= state_data_in;
      end
      if (input_reg_enable) begin
        input_cnt <= state_data_in;
      end
    end
  end

endmodule

// File: source/npu_execute.sv
`timescale 1ns/1ps

module npu_execute (
  input  logic                              CLK,
  input  logic                              RST,
  input  logic                              state_idle,
  input  logic                              input_fifo_empty,
  input  logic                              input_read,        // Sample accepted this cycle
  input  logic [npu_cfg_pkg::npu_data_w-1:0] sample,
  input  logic                              coef_write,
  input  logic                              coef_bank,
  input  logic [npu_cfg_pkg::npu_idx_w-1:0]  coef_index,
  input  logic [npu_cfg_pkg::npu_data_w-1:0] coef_value,
  output logic                              sched_input_read,
  output logic [npu_cfg_pkg::npu_acc_w-1:0]  acc
);
  import npu_cfg_pkg::*;

  logic signed [npu_data_w-1:0]   weight [2**npu_idx_w];
  logic        [npu_idx_w-1:0]    index;     // Weight of the next sample
  logic signed [2*npu_data_w-1:0] product;

  assign sched_input_read = ~input_fifo_empty;
  assign product          = $signed(sample) * weight[index];

  always_ff @(posedge CLK) begin
    if (coef_write && !coef_bank) begin        // Weight bank
      weight[coef_index] <= coef_value;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Multiply-accumulate, cleared between jobs
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge CLK) begin
    if (RST || state_idle) begin
      acc   <= '0;
      index <= '0;
    end else if (input_read) begin
      acc   <= acc + npu_acc_w'(product);      // Sign-extended product
      index <= index + 1'b1;
    end
  end

endmodule

// File: source/npu_result.sv
`timescale 1ns/1ps

module npu_result (
  input  logic                              CLK,
  input  logic                              RST,
  input  logic                              state_idle,
  input  logic                              inputs_done,
  input  logic                              output_write,      // Result pushed this cycle
  input  logic [npu_cfg_pkg::npu_acc_w-1:0]  acc,
  input  logic                              coef_write,
  input  logic                              coef_bank,
  input  logic [npu_cfg_pkg::npu_idx_w-1:0]  coef_index,
  input  logic [npu_cfg_pkg::npu_data_w-1:0] coef_value,
  output logic                              sched_output_write,
  output logic [npu_cfg_pkg::npu_data_w-1:0] result
);
  import npu_cfg_pkg::*;

  localparam int prod_w  = npu_acc_w + npu_data_w;
  localparam int sat_max = 2**(npu_data_w - 1) - 1;
  localparam int sat_min = -(2**(npu_data_w - 1));

  logic signed [npu_data_w-1:0] gain [2**npu_idx_w];
  logic        [npu_idx_w-1:0]  index;
  logic        [npu_idx_w-1:0]  next_index;   // Gain for the result loaded now
  logic signed [prod_w-1:0]     product;
  logic signed [prod_w-9:0]     scaled;
  logic        [npu_data_w-1:0] sat;
  logic                         valid;
  logic                         load;

  assign next_index = output_write ? index + 1'b1 : index;
  assign product    = $signed(acc) * gain[next_index];
  assign scaled     = product[prod_w-1:8];      // Arithmetic shift by 8
  assign load       = inputs_done & (output_write | ~valid);
  assign sched_output_write = valid;

  always_comb begin
    if (scaled > sat_max) begin
      sat = npu_data_w'(sat_max);
    end else if (scaled < sat_min) begin
      sat = npu_data_w'(sat_min);
    end else begin
      sat = scaled[npu_data_w-1:0];
    end
  end

  always_ff @(posedge CLK) begin
    if (coef_write && coef_bank) begin          // Gain bank
      gain[coef_index] <= coef_value;
    end
    if (load) begin
      result <= sat;                            // Held until written
    end
  end

  always_ff @(posedge CLK) begin
    if (RST || state_idle) begin
      index <= '0;
      valid <= 1'b0;
    end else begin
      index <= next_index;
      if (inputs_done) begin
        valid <= 1'b1;
      end
    end
  end

endmodule

// File: source/npu_top.sv
`timescale 1ns/1ps

module npu_top #(
  parameter int in_fifo_depth  = 8,
  parameter int out_fifo_depth = 4
) (
  input  logic        CLK,
  input  logic        RST,
  input  logic        cyc,
  input  logic        stb,
  input  logic        we,
  input  logic [1:0]  adr,
  input  logic [31:0] dat_i,
  output logic        ack,
  output logic [31:0] dat_o
);
  import npu_cfg_pkg::*;
  import npu_bus_pkg::*;

  logic                  cfg_push, in_push, out_pop;
  logic [31:0]           push_data;
  logic [31:0]           cfg_word;
  logic                  cfg_pop, cfg_empty, cfg_full;
  logic [npu_data_w-1:0] sample;
  logic                  in_pop, in_empty, in_full;      // in_pop is the controller read
  logic [npu_data_w-1:0] out_data;
  logic [npu_data_w-1:0] result;
  logic                  out_push, out_empty, out_full;
  logic [stat_w-1:0]     status;
  logic [npu_data_w-1:0] count_data;
  logic                  input_reg_enable, output_reg_enable;
  logic                  coef_write, coef_bank;
  logic [npu_idx_w-1:0]  coef_index;
  logic [npu_data_w-1:0] coef_value;
  logic                  state_idle, state_stall, state_compute, state_config;
  logic                  inputs_done, sched_input_read, sched_output_write;
  logic [npu_acc_w-1:0]  acc;

  assign status[stat_idle]      = state_idle;
  assign status[stat_config]    = state_config;
  assign status[stat_compute]   = state_compute;
  assign status[stat_stall]     = state_stall;
  assign status[stat_cfg_empty] = cfg_empty;
  assign status[stat_in_empty]  = in_empty;
  assign status[stat_out_empty] = out_empty;
  assign status[stat_out_full]  = out_full;

  npu_wb_slave u_bus (
    .CLK, .RST, .cyc, .stb, .we, .adr, .dat_i, .ack, .dat_o,
    .cfg_push, .in_push, .push_data, .cfg_full, .in_full,
    .out_pop, .out_data, .out_empty, .status
  );

  npu_fifo #(.depth(in_fifo_depth), .width(32)) u_cfg_fifo (
    .CLK, .RST, .push(cfg_push), .push_data(push_data), .pop(cfg_pop),
    .pop_data(cfg_word), .empty(cfg_empty), .full(cfg_full)
  );

  npu_fifo #(.depth(in_fifo_depth), .width(npu_data_w)) u_in_fifo (
    .CLK, .RST, .push(in_push), .push_data(push_data[npu_data_w-1:0]), .pop(in_pop),
    .pop_data(sample), .empty(in_empty), .full(in_full)
  );

  npu_fifo #(.depth(out_fifo_depth), .width(npu_data_w)) u_out_fifo (
    .CLK, .RST, .push(out_push), .push_data(result), .pop(out_pop),
    .pop_data(out_data), .empty(out_empty), .full(out_full)
  );

  npu_config_decode u_decode (
    .CLK, .RST, .state_config, .cfg_empty, .cfg_word, .cfg_pop, .count_data,
    .input_reg_enable, .output_reg_enable, .coef_write, .coef_bank, .coef_index, .coef_value
  );

  npu_state_machine u_ctrl (
    .CLK, .RST, .state_data_in(count_data), .output_reg_enable, .input_reg_enable,
    .config_fifo_empty(cfg_empty), .input_fifo_empty(in_empty), .sched_input_read,
    .output_fifo_full(out_full), .sched_output_write,
    .input_fifo_read_en(in_pop), .output_fifo_write_en(out_push),
    .state_idle, .state_stall, .state_compute, .state_config, .inputs_done
  );

  npu_execute u_execute (
    .CLK, .RST, .state_idle, .input_fifo_empty(in_empty), .input_read(in_pop), .sample,
    .coef_write, .coef_bank, .coef_index, .coef_value, .sched_input_read, .acc
  );

  npu_result u_result (
    .CLK, .RST, .state_idle, .inputs_done, .output_write(out_push), .acc,
    .coef_write, .coef_bank, .coef_index, .coef_value, .sched_output_write, .result
  );

endmodule

// File: verif/npu_tb.sv
`timescale 1ns/1ps

module npu_tb;
  import npu_bus_pkg::*;

  localparam string stim_file     = "verif/npu_stim.txt";
  localparam int    cycles_per_op = 200;   // Timeout budget per stim line
  localparam int    reset_cycles  = 16;

  logic        CLK;
  logic        RST;
  logic        cyc;
  logic        stb;
  logic        we;
  logic [1:0]  adr;
  logic [31:0] dat_i;
  logic        ack;
  logic [31:0] dat_o;

  logic [7:0]  op_code   [$];             // W, R or I
  logic [1:0]  op_adr    [$];
  logic [31:0] op_data   [$];             // Write data or idle cycle count
  logic [31:0] op_expect [$];             // Read data the host expects
  int          op_line   [$];             // Source line, for error lines
  int          cycle_limit = 0;
  int          cycle_count = 0;

  npu_top #(
    .in_fifo_depth (8),
    .out_fifo_depth(4)
  ) UUT (
    .CLK, .RST, .cyc, .stb, .we, .adr, .dat_i, .ack, .dat_o
  );

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;                // 10 ns period
  end

  //////////////////////////////////////////////////////////////////////
  // Failure reporting and run limit
  //////////////////////////////////////////////////////////////////////
  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("TB FAILED");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      abort_run($sformatf("** Error: %s expected %08h actual %08h", name, expected, actual));
    end
  endtask

  always @(posedge CLK) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      abort_run($sformatf("Timeout after %0d cycles, the bus stopped answering",
                          cycle_count));
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stim file parsing
  //////////////////////////////////////////////////////////////////////
  task automatic load_stim();
    int               fd;
    int               n;
    int               line_no;
    logic [8*16-1:0]  tok;
    logic [8*256-1:0] rest;
    logic [31:0]      f_adr;
    logic [31:0]      f_data;
    logic [31:0]      f_exp;
    line_no = 0;
    fd = $fopen(stim_file, "r");
    if (fd == 0) begin
      abort_run({"Cannot open the stimulus file ", stim_file});
    end else begin
      while (!$feof(fd)) begin
        n = $fscanf(fd, "%s", tok);       // Op letter or comment mark
        if (n != 1) break;
        line_no++;
        if (tok == "#") begin
          void'($fgets(rest, fd));        // Skip comment text
        end else if (tok == "W" || tok == "R" || tok == "I") begin
          n = $fscanf(fd, "%h %h %h", f_adr, f_data, f_exp);
          if (n != 3) begin
            abort_run($sformatf("Stim line %0d is missing fields", line_no));
          end else begin
            op_code.push_back(tok[7:0]);
            op_adr.push_back(f_adr[1:0]);
            op_data.push_back(f_data);
            op_expect.push_back(f_exp);
            op_line.push_back(line_no);
          end
        end else begin
          abort_run($sformatf("Stim line %0d has an unknown operation", line_no));
        end
      end
      $fclose(fd);
    end
    if (op_code.size() == 0) begin
      abort_run("The stimulus file holds no operations");
    end
  endtask

  // One Wishbone classic cycle, entered and left on a falling edge
  task automatic bus_cycle(input logic write, input logic [1:0] addr,
                           input logic [31:0] data, output logic [31:0] rdata);
    cyc   = 1'b1;
    stb   = 1'b1;
    we    = write;
    adr   = addr;
    dat_i = data;
    @(negedge CLK);
    while (!ack) begin                    // Back-pressure holds ack low
      @(negedge CLK);
    end
    rdata = dat_o;                        // Stable mid ack cycle
    cyc   = 1'b0;
    stb   = 1'b0;
    @(negedge CLK);                       // adr and we held through the push or pop
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////
  initial begin
    logic [31:0] rdata;
    string       name;
    cyc   = 1'b0;
    stb   = 1'b0;
    we    = 1'b0;
    adr   = 2'd0;
    dat_i = 32'd0;
    RST   = 1'b1;
    load_stim();
    cycle_limit = cycles_per_op * op_code.size();
    repeat (reset_cycles) @(posedge CLK);
    @(negedge CLK);
    RST = 1'b0;
    for (int i = 0; i < op_code.size(); i++) begin
      case (op_code[i])
        "W": bus_cycle(1'b1, op_adr[i], op_data[i], rdata);
        "R": begin
          bus_cycle(1'b0, op_adr[i], 32'd0, rdata);
          name = $sformatf("stim line %0d %s read", op_line[i],
                           (op_adr[i] == addr_status) ? "status" : "result");
          check_value(name, op_expect[i], rdata);
        end
        default: repeat (op_data[i]) @(negedge CLK);  // Idle gap
      endcase
    end
    $display("TB PASSED");
    $finish;
  end

endmodule

// File: verif/npu_stim.txt
# op adr data expect, all fields hex; I waits data cycles, expect is used by R only
# adr 0 config push, 1 input push, 2 result pop, 3 status
# Reset state idle with all FIFOs empty
R 3 0 71
# Config 4 inputs, 3 outputs, weights 3 -2 5 1, gains 256 128 -512
W 0 40000004 0
W 0 60000003 0
W 0 80000003 0
W 0 8001FFFE 0
W 0 80020005 0
W 0 80030001 0
W 0 A0000100 0
W 0 A0010080 0
W 0 A002FE00 0
I 0 A 0
# Job with samples 100 200 -50 1000, acc 650
W 1 0064 0
W 1 00C8 0
W 1 FFCE 0
W 1 03E8 0
R 2 0 028A
R 2 0 0145
R 2 0 FAEC
# Same job with gaps, controller stalls waiting for input
W 1 0064 0
I 0 6 0
R 3 0 78
W 1 00C8 0
I 0 6 0
W 1 FFCE 0
I 0 6 0
W 1 03E8 0
R 2 0 028A
R 2 0 0145
R 2 0 FAEC
# Six outputs into a depth 4 output FIFO, gains 64 -256 512 added
W 0 60000006 0
W 0 A0030040 0
W 0 A004FF00 0
W 0 A0050200 0
I 0 A 0
W 1 000A 0
W 1 0014 0
W 1 001E 0
W 1 0028 0
# Output FIFO full with a result waiting, controller stalls
I 0 28 0
R 3 0 B8
R 2 0 00B4
R 2 0 005A
R 2 0 FE98
R 2 0 002D
R 2 0 FF4C
R 2 0 0168
# Second job on stored coefficients, samples -100 50 7 -3, acc -368
W 1 FF9C 0
W 1 0032 0
W 1 0007 0
W 1 FFFD 0
R 2 0 FE90
R 2 0 FF48
R 2 0 02E0
R 2 0 FFA4
R 2 0 0170
R 2 0 FD20
I 0 A 0
R 3 0 71
# Saturation with two full scale samples, weights and gains
W 0 40000002 0
W 0 60000002 0
W 0 80007FFF 0
W 0 80017FFF 0
W 0 A0007FFF 0
W 0 A0018000 0
I 0 A 0
W 1 7FFF 0
W 1 7FFF 0
R 2 0 7FFF
R 2 0 8000

// File: project.f
source/npu_cfg_pkg.sv
source/npu_bus_pkg.sv
source/npu_fifo.sv
source/npu_wb_slave.sv
source/npu_config_decode.sv
source/npu_state_machine.sv
source/npu_execute.sv
source/npu_result.sv
source/npu_top.sv
verif/npu_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= npu_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -Wno-fatal -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
